// File: Makefile
VERILATOR   = verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert
TOP         = tb_rv_core
FILELIST    = rv_core.f
BUILD_DIR   = obj_dir
LOG         = sim.log
FAIL_MSG    = Errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/decode_unit.sv
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  rv_isa_pkg::word_t     id_pc,
	input  rv_isa_pkg::word_t     id_instr,
	input  logic                  flush,
	input  logic                  stall,
	input  rv_isa_pkg::word_t     rs1_data,
	input  rv_isa_pkg::word_t     rs2_data,
	output rv_isa_pkg::reg_addr_t rs1,
	output rv_isa_pkg::reg_addr_t rs2,
	output rv_pipe_pkg::ctrl_t    ex_ctrl,
	output rv_isa_pkg::word_t     ex_pc,
	output rv_isa_pkg::word_t     ex_a,
	output rv_isa_pkg::word_t     ex_b,
	output rv_isa_pkg::word_t     ex_imm,
	output rv_isa_pkg::reg_addr_t ex_rs1,
	output rv_isa_pkg::reg_addr_t ex_rs2,
	output rv_isa_pkg::reg_addr_t ex_rd
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	opcode_e   opcode;
	funct3_t   funct3;
	funct7_t   funct7;
	reg_addr_t rd;
	ctrl_t     ctrl;
	word_t     imm;

	assign opcode = opcode_e'(id_instr[6:0]);
	assign funct3 = id_instr[14:12];
	assign funct7 = id_instr[31:25];
	assign rs1    = id_instr[19:15];
	assign rs2    = id_instr[24:20];
	assign rd     = id_instr[11:7];

	// main control, anything outside the subset becomes a bubble
	always_comb begin
		ctrl = '0;
		case (opcode)
			op_reg: begin
				ctrl.reg_write = 1'b1;
				case (funct3)
					add_sub: ctrl.alu_op = (funct7 == funct7_sub) ? alu_sub : alu_add;
					slt:     ctrl.alu_op = alu_slt;
					xor_op:  ctrl.alu_op = alu_xor;
					or_op:   ctrl.alu_op = alu_or;
					and_op:  ctrl.alu_op = alu_and;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			op_imm: begin
				// addi only
				ctrl.reg_write   = (funct3 == add_sub);
				ctrl.alu_src_imm = 1'b1;
			end
			op_load: begin
				ctrl.reg_write   = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_store: begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			op_branch: ctrl.is_branch = (funct3 == beq);
			op_jal: begin
				ctrl.reg_write = 1'b1;
				ctrl.is_jal    = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	// immediate format follows the opcode, I type otherwise
	always_comb begin
		case (opcode)
			op_store:  imm = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
			op_branch: imm = {{20{id_instr[31]}}, id_instr[7], id_instr[30:25],
					id_instr[11:8], 1'b0};
			op_jal:    imm = {{12{id_instr[31]}}, id_instr[19:12], id_instr[20],
					id_instr[30:21], 1'b0};
			default:   imm = {{20{id_instr[31]}}, id_instr[31:20]};
		endcase
	end

	// bubble into execute on load-use or redirect
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_ctrl <= '0;
		end else if (flush || stall) begin
			ex_ctrl <= '0;
		end else begin
			ex_ctrl <= ctrl;
		end
	end

	always_ff @(posedge clock) begin
		ex_pc  <= id_pc;
		ex_a   <= rs1_data;
		ex_b   <= rs2_data;
		ex_imm <= imm;
		ex_rs1 <= rs1;
		ex_rs2 <= rs2;
		ex_rd  <= rd;
	end
endmodule

`default_nettype wire

// File: hw/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  rv_pipe_pkg::ctrl_t    ex_ctrl,
	input  rv_isa_pkg::word_t     ex_pc,
	input  rv_isa_pkg::word_t     ex_a,
	input  rv_isa_pkg::word_t     ex_b,
	input  rv_isa_pkg::word_t     ex_imm,
	input  rv_isa_pkg::reg_addr_t ex_rs1,
	input  rv_isa_pkg::reg_addr_t ex_rs2,
	input  rv_isa_pkg::reg_addr_t ex_rd,
	input  logic                  wb_en,
	input  rv_isa_pkg::reg_addr_t wb_rd,
	input  rv_isa_pkg::word_t     wb_data,
	exmem_if.producer             mem,
	output logic                  redirect,
	output rv_isa_pkg::word_t     redirect_target
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	fwd_sel_e fwd_a;
	fwd_sel_e fwd_b;
	word_t    op_a;
	word_t    op_b;
	word_t    alu_b;
	word_t    alu_out;
	word_t    result;

	// memory stage holds the younger result, so it wins
	function automatic fwd_sel_e fwd_source(input reg_addr_t rs, input reg_addr_t mem_rd,
			input logic mem_wr, input reg_addr_t wb_dst, input logic wb_wr);
		fwd_sel_e sel;
		sel = fwd_none;
		if (rs != '0 && mem_wr && mem_rd == rs) begin
			sel = fwd_mem;
		end else if (rs != '0 && wb_wr && wb_dst == rs) begin
			sel = fwd_wb;
		end
		return sel;
	endfunction

	function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
			input word_t mem_val, input word_t wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	always_comb begin
		fwd_a = fwd_source(ex_rs1, mem.rd, mem.reg_write, wb_rd, wb_en);
		fwd_b = fwd_source(ex_rs2, mem.rd, mem.reg_write, wb_rd, wb_en);
		op_a  = fwd_mux(fwd_a, ex_a, mem.alu_result, wb_data);
		op_b  = fwd_mux(fwd_b, ex_b, mem.alu_result, wb_data);
	end

	assign alu_b = ex_ctrl.alu_src_imm ? ex_imm : op_b;

	always_comb begin
		case (ex_ctrl.alu_op)
			alu_sub: alu_out = op_a - alu_b;
			alu_and: alu_out = op_a & alu_b;
			alu_or:  alu_out = op_a | alu_b;
			alu_xor: alu_out = op_a ^ alu_b;
			alu_slt: alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
			default: alu_out = op_a + alu_b;
		endcase
	end

	// jal writes its return address
	assign result = ex_ctrl.is_jal ? ex_pc + 32'd4 : alu_out;

	assign redirect        = ex_ctrl.is_jal || (ex_ctrl.is_branch && op_a == op_b);
	assign redirect_target = ex_pc + ex_imm;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			mem.reg_write <= 1'b0;
			mem.mem_read  <= 1'b0;
			mem.mem_write <= 1'b0;
		end else begin
			mem.reg_write <= ex_ctrl.reg_write;
			mem.mem_read  <= ex_ctrl.mem_read;
			mem.mem_write <= ex_ctrl.mem_write;
		end
	end

	always_ff @(posedge clock) begin
		mem.rd         <= ex_rd;
		mem.alu_result <= result;
		mem.store_data <= op_b;
	end
endmodule

`default_nettype wire

// File: hw/exmem_if.sv
`timescale 1ns/1ns
`default_nettype none

interface exmem_if;
	import rv_isa_pkg::*;

	// a bubble has all three control bits low
	logic      reg_write;
	logic      mem_read;
	logic      mem_write;
	reg_addr_t rd;
	word_t     alu_result;
	word_t     store_data;

	modport producer (
		output reg_write, mem_read, mem_write, rd, alu_result, store_data
	);

	modport consumer (
		input reg_write, mem_read, mem_write, rd, alu_result, store_data
	);
endinterface

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
	parameter rv_isa_pkg::word_t reset_vector = '0
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              stall,
	input  logic              redirect,
	input  rv_isa_pkg::word_t redirect_target,
	input  rv_isa_pkg::word_t instr,
	output rv_isa_pkg::word_t pc,
	output rv_isa_pkg::word_t id_pc,
	output rv_isa_pkg::word_t id_instr
);
	import rv_isa_pkg::*;

	word_t pc_next;

	// a taken branch or jal wins over a load-use hold
	always_comb begin
		if (redirect) begin
			pc_next = redirect_target;
		end else if (stall) begin
			pc_next = pc;
		end else begin
			pc_next = pc + 32'd4;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_vector;
		end else begin
			pc <= pc_next;
		end
	end

	// fetch/decode register, the word itself acts as control
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_instr <= nop_instr;
		end else if (redirect) begin
			id_instr <= nop_instr;
		end else if (!stall) begin
			id_instr <= instr;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			id_pc <= pc;
		end
	end
endmodule

`default_nettype wire

// File: hw/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
	input  logic                  ex_mem_read,
	input  rv_isa_pkg::reg_addr_t ex_rd,
	input  rv_isa_pkg::reg_addr_t rs1,
	input  rv_isa_pkg::reg_addr_t rs2,
	input  logic                  redirect,
	output logic                  stall,
	output logic                  flush
);
	logic rd_match;
	logic load_use;

	// rs2 is compared even for I type, an extra stall is harmless
	assign rd_match = (ex_rd == rs1) || (ex_rd == rs2);

	// load data only exists after the memory stage
	assign load_use = ex_mem_read && (ex_rd != 5'd0) && rd_match;

	// decode is discarded on redirect, so no hold then
	assign stall = load_use && !redirect;
	assign flush = redirect;
endmodule

`default_nettype wire

// File: hw/mem_wb_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wb_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  rv_isa_pkg::word_t     data_rdata,
	exmem_if.consumer             mem,
	output rv_isa_pkg::word_t     data_addr,
	output rv_isa_pkg::word_t     data_wdata,
	output logic                  data_wen,
	output logic                  data_ren,
	output logic                  wb_en,
	output rv_isa_pkg::reg_addr_t wb_rd,
	output rv_isa_pkg::word_t     wb_data
);
	import rv_isa_pkg::*;

	logic  wb_load;
	word_t wb_rdata;
	word_t wb_alu;

	// data memory answers within the cycle
	assign data_addr  = mem.alu_result;
	assign data_wdata = mem.store_data;
	assign data_wen   = mem.mem_write;
	assign data_ren   = mem.mem_read;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_en   <= 1'b0;
			wb_load <= 1'b0;
		end else begin
			// writes to x0 die here
			wb_en   <= mem.reg_write && mem.rd != '0;
			wb_load <= mem.mem_read;
		end
	end

	always_ff @(posedge clock) begin
		wb_rd    <= mem.rd;
		wb_rdata <= data_rdata;
		wb_alu   <= mem.alu_result;
	end

	assign wb_data = wb_load ? wb_rdata : wb_alu;
endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  logic                   clock,
	input  logic                   reset,
	input  rv_isa_pkg::reg_addr_t  rs1,
	input  rv_isa_pkg::reg_addr_t  rs2,
	input  logic                   wb_en,
	input  rv_isa_pkg::reg_addr_t  wb_rd,
	input  rv_isa_pkg::word_t      wb_data,
	output rv_isa_pkg::word_t      rs1_data,
	output rv_isa_pkg::word_t      rs2_data
);
	import rv_isa_pkg::*;

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end else if (wb_en && wb_rd == addr) begin
			// write-first, writeback result seen by decode this cycle
			return wb_data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs1_data = read_port(rs1);
		rs2_data = read_port(rs2);
	end
endmodule

`default_nettype wire

// File: hw/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
	parameter rv_isa_pkg::word_t reset_vector = '0
) (
	input  logic              clock,
	input  logic              reset,
	input  rv_isa_pkg::word_t instr,
	input  rv_isa_pkg::word_t data_rdata,
	output rv_isa_pkg::word_t pc,
	output rv_isa_pkg::word_t data_addr,
	output rv_isa_pkg::word_t data_wdata,
	output logic              data_wen,
	output logic              data_ren
);
	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	// fetch to decode
	word_t     id_pc;
	word_t     id_instr;

	// register file reads
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t     rs1_data;
	word_t     rs2_data;

	// decode to execute
	ctrl_t     ex_ctrl;
	word_t     ex_pc;
	word_t     ex_a;
	word_t     ex_b;
	word_t     ex_imm;
	reg_addr_t ex_rs1;
	reg_addr_t ex_rs2;
	reg_addr_t ex_rd;

	// hazard and redirect
	logic      stall;
	logic      flush;
	logic      redirect;
	word_t     redirect_target;

	// writeback
	logic      wb_en;
	reg_addr_t wb_rd;
	word_t     wb_data;

	exmem_if ex_mem ();

	fetch_unit #(.reset_vector(reset_vector)) fetch0 (.*);

	reg_file regs0 (.*);

	decode_unit decode0 (.*);

	hazard_unit hazard0 (
		.*,
		.ex_mem_read(ex_ctrl.mem_read)
	);

	execute_unit execute0 (
		.*,
		.mem(ex_mem)
	);

	mem_wb_unit mem_wb0 (
		.*,
		.mem(ex_mem)
	);
endmodule

`default_nettype wire

// File: hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// data and address word
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		op_reg    = 7'b0110011,
		op_imm    = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_e;

	// funct3 of register and immediate alu ops
	localparam funct3_t add_sub = 3'b000;
	localparam funct3_t slt     = 3'b010;
	localparam funct3_t xor_op  = 3'b100;
	localparam funct3_t or_op   = 3'b110;
	localparam funct3_t and_op  = 3'b111;

	// only branch condition kept
	localparam funct3_t beq = 3'b000;

	// funct7 that turns add into sub
	localparam funct7_t funct7_sub = 7'b0100000;

	// opcode zero matches no case in decode
	localparam word_t nop_instr = 32'h0000_0000;

endpackage

`default_nettype wire

// File: hw/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

	// alu_add first so an all-zero bundle adds
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_e;

	// decoded control carried from decode into execute
	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    alu_src_imm;
		logic    is_branch;
		logic    is_jal;
		alu_op_e alu_op;
	} ctrl_t;

	// operand source in execute
	typedef enum logic [1:0] {
		fwd_none,
		fwd_mem,
		fwd_wb
	} fwd_sel_e;

endpackage

`default_nettype wire

// File: rv_core.f
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/exmem_if.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/decode_unit.sv
hw/hazard_unit.sv
hw/execute_unit.sv
hw/mem_wb_unit.sv
hw/rv_core.sv
testbench/rv_core_sva.sv
testbench/tb_rv_core.sv

// File: testbench/rv_core_sva.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_sva (
	input logic        clock,
	input logic        reset,
	input logic [31:0] pc,
	input logic        data_wen,
	input logic        data_ren
);
	// one data port, a load and a store never share a cycle
	no_read_write: assert property (@(posedge clock) disable iff (!reset)
		!(data_wen && data_ren))
		else $error("data_wen and data_ren high in the same cycle");

	pc_aligned: assert property (@(posedge clock) disable iff (!reset)
		pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned", pc);

	// memory stage still holds a bubble right after reset
	quiet_after_reset: assert property (@(posedge clock)
		$rose(reset) |-> !data_wen)
		else $error("store in the first cycle after reset");
endmodule

`default_nettype wire

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;
	localparam logic [31:0] boot_addr = 32'h0000_0200;
	localparam logic [31:0] done_addr = 32'h0000_03fc;
	localparam int max_cycles = 200;

	logic        clock;
	logic        reset;
	logic [31:0] instr;
	logic [31:0] data_rdata;
	logic [31:0] pc;
	logic [31:0] data_addr;
	logic [31:0] data_wdata;
	logic        data_wen;
	logic        data_ren;

	logic [31:0] rom [0:63];
	logic [31:0] dram [0:255];
	logic [31:0] rom_off;
	logic [31:0] st_addr [$];
	logic [31:0] st_data [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic        done;
	logic [31:0] rng;
	int          prog_len;
	int          errors;
	int          errors_before;
	int          tests;
	int          failed;

	rv_core #(.reset_vector(boot_addr)) dut0 (.*);

	bind rv_core rv_core_sva sva0 (.*);

	// both memories answer in the same cycle
	assign rom_off    = pc - boot_addr;
	assign instr      = rom[rom_off[7:2]];
	// data port returns a poison word unless data_ren is high
	assign data_rdata = data_ren ? dram[data_addr[9:2]] : 32'hbad0_0bad;

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// data RAM writes and store log, refilled while reset is low
	always @(negedge clock) begin
		if (!reset) begin
			st_addr.delete();
			st_data.delete();
			done = 1'b0;
			for (int i = 0; i < 256; i++) begin
				dram[i] = 32'h5eed_0000 | (i * 4);
			end
		end else if (data_wen) begin
			dram[data_addr[9:2]] = data_wdata;
			st_addr.push_back(data_addr);
			st_data.push_back(data_wdata);
			if (data_addr == done_addr) begin
				done = 1'b1;
			end
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [11:0] next_imm();
		rng = xorshift(rng);
		return rng[11:0];
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// RV32I instruction encoders
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_beq(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic flag_mismatch(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		$display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, expected);
		errors++;
	endtask

	task automatic begin_test();
		for (int i = 0; i < 64; i++) begin
			rom[i] = 32'h0;
		end
		prog_len = 0;
		exp_addr.delete();
		exp_data.delete();
		errors_before = errors;
	endtask

	task automatic emit(input logic [31:0] word);
		rom[prog_len] = word;
		prog_len++;
	endtask

	// sw rs to a fixed slot, with the value it must carry
	task automatic store_word(input logic [4:0] rs, input logic [11:0] off,
			input logic [31:0] value);
		emit(enc_sw(rs, 5'd0, off));
		exp_addr.push_back({20'd0, off});
		exp_data.push_back(value);
	endtask

	task automatic finish_program();
		store_word(5'd0, done_addr[11:0], 32'd0);
	endtask

	task automatic pulse_reset();
		@(posedge clock);
		reset <= 1'b0;
		repeat (4) @(posedge clock);
		reset <= 1'b1;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!done && n < max_cycles) begin
			@(posedge clock);
			n++;
		end
		assert (done) else begin
			$display("timeout at %0t: program never finished, no store to the done address",
				$time);
			errors++;
		end
	endtask

	task automatic compare_stores();
		assert (st_addr.size() == exp_addr.size())
			else flag_mismatch("number of stores", st_addr.size(), exp_addr.size());
		for (int i = 0; i < exp_addr.size() && i < st_addr.size(); i++) begin
			assert (st_addr[i] == exp_addr[i])
				else flag_mismatch($sformatf("address of store %0d", i), st_addr[i], exp_addr[i]);
			assert (st_data[i] == exp_data[i])
				else flag_mismatch($sformatf("data of store %0d", i), st_data[i], exp_data[i]);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic test_reset();
		int n;
		begin_test();
		emit(enc_addi(5'd1, 5'd0, 12'h123));
		emit(enc_addi(5'd2, 5'd1, 12'h001));
		emit(enc_addi(5'd3, 5'd2, 12'h7ff));
		store_word(5'd3, 12'h020, 32'h123 + 32'h1 + 32'h7ff);
		finish_program();
		pulse_reset();
		@(negedge clock);
		assert (pc == boot_addr) else flag_mismatch("first pc after reset", pc, boot_addr);
		// store at index 3 reaches memory three cycles after fetch
		n = 0;
		while (!data_wen && n < max_cycles) begin
			@(negedge clock);
			n++;
		end
		assert (data_wen) else begin
			$display("timeout at %0t: first store never reached the data port", $time);
			errors++;
		end
		assert (n == 6) else flag_mismatch("cycles until the first store", n, 6);
		wait_done();
		compare_stores();
		end_test("reset");
	endtask

	task automatic test_alu();
		logic [11:0] a;
		logic [11:0] b;
		logic [11:0] c;
		logic [31:0] va;
		logic [31:0] vb;
		logic [31:0] vc;
		begin_test();
		a = next_imm();
		b = next_imm();
		c = next_imm() | 12'h800;
		va = sext12(a);
		vb = sext12(b);
		vc = sext12(c);
		emit(enc_addi(5'd1, 5'd0, a));
		emit(enc_addi(5'd2, 5'd0, b));
		emit(enc_addi(5'd3, 5'd0, c));
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
		emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5));
		emit(enc_r(7'h00, 5'd3, 5'd1, 3'b111, 5'd6));
		emit(enc_r(7'h00, 5'd3, 5'd2, 3'b110, 5'd7));
		emit(enc_r(7'h00, 5'd3, 5'd1, 3'b100, 5'd8));
		emit(enc_r(7'h00, 5'd1, 5'd3, 3'b010, 5'd9));
		emit(enc_r(7'h00, 5'd3, 5'd1, 3'b010, 5'd10));
		// x0 must stay zero
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
		store_word(5'd0, 12'h000, 32'd0);
		store_word(5'd4, 12'h004, va + vb);
		store_word(5'd5, 12'h008, va - vb);
		store_word(5'd6, 12'h00c, va & vc);
		store_word(5'd7, 12'h010, vb | vc);
		store_word(5'd8, 12'h014, va ^ vc);
		store_word(5'd9, 12'h018, ($signed(vc) < $signed(va)) ? 32'd1 : 32'd0);
		store_word(5'd10, 12'h01c, ($signed(va) < $signed(vc)) ? 32'd1 : 32'd0);
		finish_program();
		pulse_reset();
		wait_done();
		compare_stores();
		end_test("alu");
	endtask

	task automatic test_forwarding();
		logic [11:0] a;
		logic [11:0] b;
		logic [31:0] v [1:7];
		begin_test();
		a = next_imm();
		b = next_imm();
		v[1] = sext12(a);
		v[2] = v[1] + v[1];
		v[3] = v[2] - v[1];
		v[4] = v[3] ^ v[2];
		v[5] = v[4] + sext12(b);
		v[6] = v[5] | v[3];
		v[7] = ($signed(v[6]) < $signed(v[5])) ? 32'd1 : 32'd0;
		// each step uses the previous result and the one before it
		emit(enc_addi(5'd1, 5'd0, a));
		emit(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
		emit(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
		emit(enc_r(7'h00, 5'd2, 5'd3, 3'b100, 5'd4));
		emit(enc_addi(5'd5, 5'd4, b));
		emit(enc_r(7'h00, 5'd3, 5'd5, 3'b110, 5'd6));
		emit(enc_r(7'h00, 5'd5, 5'd6, 3'b010, 5'd7));
		for (int r = 7; r >= 1; r--) begin
			store_word(5'(r), 12'h040 + 12'(4 * r), v[r]);
		end
		finish_program();
		pulse_reset();
		wait_done();
		compare_stores();
		end_test("forwarding");
	endtask

	task automatic test_load_use();
		logic [11:0] a;
		logic [11:0] b;
		begin_test();
		a = next_imm();
		b = next_imm();
		emit(enc_addi(5'd1, 5'd0, a));
		store_word(5'd1, 12'h060, sext12(a));
		emit(enc_lw(5'd2, 5'd0, 12'h060));
		emit(enc_addi(5'd3, 5'd2, b));
		store_word(5'd3, 12'h064, sext12(a) + sext12(b));
		// loaded value used as rs2
		emit(enc_lw(5'd4, 5'd0, 12'h060));
		emit(enc_r(7'h00, 5'd4, 5'd0, 3'b000, 5'd5));
		store_word(5'd5, 12'h068, sext12(a));
		finish_program();
		pulse_reset();
		wait_done();
		compare_stores();
		end_test("load_use");
	endtask

	task automatic test_control_flow();
		begin_test();
		emit(enc_addi(5'd1, 5'd0, 12'd7));
		emit(enc_addi(5'd2, 5'd0, 12'd7));
		emit(enc_beq(5'd1, 5'd2, 13'd12));
		// flushed slots, these stores must not reach memory
		emit(enc_sw(5'd1, 5'd0, 12'h080));
		emit(enc_sw(5'd1, 5'd0, 12'h084));
		emit(enc_addi(5'd3, 5'd0, 12'd9));
		emit(enc_beq(5'd1, 5'd3, 13'd12));
		store_word(5'd3, 12'h010, 32'd9);
		emit(enc_jal(5'd5, 21'd12));
		emit(enc_sw(5'd1, 5'd0, 12'h088));
		emit(enc_sw(5'd1, 5'd0, 12'h08c));
		// jal sits at index 8
		store_word(5'd5, 12'h014, boot_addr + 32'd32 + 32'd4);
		finish_program();
		pulse_reset();
		wait_done();
		compare_stores();
		end_test("control_flow");
	endtask

	initial begin
		reset = 1'b0;
		rng = 32'hdbb4;
		errors = 0;
		tests = 0;
		failed = 0;
		test_reset();
		test_alu();
		test_forwarding();
		test_load_use();
		test_control_flow();
		$display("summary: %0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end
endmodule

`default_nettype wire
